//--- Bender.yml
package:
  name: acc_lockstep

sources:
  # Lockstep checker RTL, package first
  - files:
      - verilog/lockstep_pkg.sv
      - verilog/lockstep_rst_ctrl.sv
      - verilog/lockstep_delay_line.sv
      - verilog/acc_core.sv
      - verilog/lockstep_compare.sv
      - verilog/acc_lockstep.sv

  # Testbench, includes sim/tb_model.svh
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_acc_lockstep.sv

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////////////
// Main core model
//////////////////////////////////////////////////////////////////////////////

// Registered response of the main core with the accumulator in the result field
core_rsp_t  model_rsp;
// Command presented to the main core in the current cycle
core_cmd_t  model_cmd;

// Expected alerts per cycle with bit 1 major and bit 0 minor
logic [1:0] exp_alert_q[$];

function automatic bit op_is_legal(input acc_op_e op);
  case (op)
    OP_LOAD, OP_ADD, OP_SUB, OP_XOR, OP_AND: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic bit cmd_is_illegal(input core_cmd_t c);
  return c.cmd_valid && !op_is_legal(c.op);
endfunction

function automatic core_rsp_t main_core_next(input core_rsp_t prev, input core_cmd_t c);
  core_rsp_t         nxt;
  logic [DATA_W-1:0] acc;
  acc = prev.result;
  if (c.cmd_valid) begin
    case (c.op)
      OP_LOAD: acc = c.operand;
      OP_ADD:  acc = acc + c.operand;
      OP_SUB:  acc = acc - c.operand;
      OP_XOR:  acc = acc ^ c.operand;
      OP_AND:  acc = acc & c.operand;
      default: acc = prev.result;
    endcase
  end
  nxt.rsp_valid = c.cmd_valid;
  nxt.illegal   = cmd_is_illegal(c);
  nxt.result    = acc;
  return nxt;
endfunction

// Cycles before the first stimulus can never carry an alert
function automatic void clear_expectations();
  exp_alert_q.delete();
  for (int i = 0; i < OUTPUTS_OFFSET; i++) begin
    exp_alert_q.push_back(2'b00);
  end
endfunction

function automatic int unsigned pending_alerts();
  int unsigned n;
  n = 0;
  foreach (exp_alert_q[i]) begin
    if (exp_alert_q[i] != 2'b00) begin
      n++;
    end
  end
  return n;
endfunction

`endif

//--- sim/tb_acc_lockstep.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acc_lockstep import lockstep_pkg::*; ();

  localparam int unsigned CLK_HALF      = 20;
  localparam int unsigned RESET_CYCLES  = 5;
  localparam int unsigned RESET_TIMEOUT = 16;
  localparam int unsigned ALERT_TIMEOUT = 12;
  localparam int unsigned DRAIN_TIMEOUT = 16;
  localparam int unsigned RSP_W         = $bits(core_rsp_t);

  logic      clk;
  logic      rst_n;
  core_cmd_t cmd;
  core_rsp_t main_rsp;
  logic      alert_major;
  logic      alert_minor;

  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned fail_cnt;
  bit          timed_out;

  `include "tb_model.svh"

  acc_lockstep dut_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .cmd_i         (cmd),
    .main_rsp_i    (main_rsp),
    .alert_major_o (alert_major),
    .alert_minor_o (alert_minor)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_cnt++;
    timed_out = 1'b1;
    $display("timeout at %0t: gave up waiting for %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic core_cmd_t rand_cmd(input bit allow_illegal, input int unsigned valid_pct);
    core_cmd_t c;
    c.cmd_valid = (($urandom % 100) < valid_pct);
    if (allow_illegal) begin
      c.op = acc_op_e'(3'($urandom % 8));
    end else begin
      c.op = acc_op_e'(3'($urandom % 5));
    end
    c.operand = $urandom;
    return c;
  endfunction

  // Codes above OP_AND
  function automatic core_cmd_t illegal_cmd();
    core_cmd_t c;
    c.cmd_valid = 1'b1;
    c.op        = acc_op_e'(3'(5 + $urandom % 3));
    c.operand   = $urandom;
    return c;
  endfunction

  function automatic logic [RSP_W-1:0] bit_flip();
    logic [RSP_W-1:0] flip;
    flip = '0;
    flip[$urandom % RSP_W] = 1'b1;
    return flip;
  endfunction

  // Drive on the rising edge and check alerts on the falling edge
  task automatic step_cycle(input core_cmd_t next_cmd, input logic [RSP_W-1:0] flip);
    core_rsp_t  rsp_next;
    logic [1:0] due;
    @(posedge clk);
    // Main core answers the command of the cycle that just ended
    rsp_next  = main_core_next(model_rsp, model_cmd);
    model_rsp = rsp_next;
    model_cmd = next_cmd;
    main_rsp <= rsp_next ^ flip;
    cmd      <= next_cmd;
    exp_alert_q.push_back({flip != '0, cmd_is_illegal(next_cmd)});
    @(negedge clk);
    due = exp_alert_q.pop_front();
    check_value("alert_major_o", alert_major, due[1]);
    check_value("alert_minor_o", alert_minor, due[0]);
  endtask

  task automatic wait_reset_done();
    int unsigned n;
    n = 0;
    while (dut_i.cmp_en !== 1'b1 && n < RESET_TIMEOUT) begin
      step_cycle('0, '0);
      n++;
    end
    if (dut_i.cmp_en !== 1'b1) begin
      report_timeout("the compare enable after reset");
    end
  endtask

  // Keeps legal traffic running until the alert shows up
  task automatic wait_alert(input bit major, output int unsigned delay);
    delay = 0;
    while ((major ? alert_major : alert_minor) !== 1'b1 && delay < ALERT_TIMEOUT) begin
      step_cycle(rand_cmd(1'b0, 80), '0);
      delay++;
    end
    if ((major ? alert_major : alert_minor) !== 1'b1) begin
      report_timeout(major ? "alert_major_o to rise" : "alert_minor_o to rise");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_test();
    int unsigned errs;
    errs = err_cnt;
    repeat (20) step_cycle('0, '0);
    finish_test("idle after reset", errs);
  endtask

  task automatic legal_test();
    int unsigned errs;
    errs = err_cnt;
    repeat (300) step_cycle(rand_cmd(1'b0, 80), '0);
    finish_test("random legal commands", errs);
  endtask

  task automatic fault_test();
    int unsigned errs;
    int unsigned delay;
    errs = err_cnt;
    for (int n = 0; n < 16; n++) begin
      repeat (1 + $urandom % 6) step_cycle(rand_cmd(1'b0, 80), '0);
      step_cycle(rand_cmd(1'b0, 80), bit_flip());
      wait_alert(1'b1, delay);
      if (timed_out) begin
        break;
      end
      check_value("alert_major_o delay", delay, OUTPUTS_OFFSET);
    end
    finish_test("fault injection", errs);
  endtask

  task automatic illegal_test();
    int unsigned errs;
    int unsigned delay;
    errs = err_cnt;
    for (int n = 0; n < 12; n++) begin
      repeat (1 + $urandom % 6) step_cycle(rand_cmd(1'b0, 80), '0);
      step_cycle(illegal_cmd(), '0);
      wait_alert(1'b0, delay);
      if (timed_out) begin
        break;
      end
      check_value("alert_minor_o delay", delay, OUTPUTS_OFFSET);
    end
    finish_test("illegal opcodes", errs);
  endtask

  task automatic mixed_test();
    int unsigned errs;
    errs = err_cnt;
    repeat (400) begin
      step_cycle(rand_cmd(1'b1, 70), (($urandom % 20) == 0) ? bit_flip() : '0);
    end
    finish_test("mixed traffic with faults", errs);
  endtask

  task automatic drain_pipeline();
    int unsigned n;
    n = 0;
    while (pending_alerts() != 0 && n < DRAIN_TIMEOUT) begin
      step_cycle('0, '0);
      n++;
    end
    if (pending_alerts() != 0) begin
      report_timeout("the expected alerts to drain");
    end
  endtask

  initial begin
    void'($urandom(86110));
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd       = '0;
    main_rsp  = '0;
    model_cmd = '0;
    model_rsp = '0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    clear_expectations();

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    wait_reset_done();
    // Let both delay lines fill with idle traffic
    if (!timed_out) repeat (LOCKSTEP_OFFSET + 2) step_cycle('0, '0);
    if (!timed_out) idle_test();
    if (!timed_out) legal_test();
    if (!timed_out) fault_test();
    if (!timed_out) illegal_test();
    if (!timed_out) mixed_test();
    if (!timed_out) drain_pipeline();

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+sim
verilog/lockstep_pkg.sv
verilog/lockstep_rst_ctrl.sv
verilog/lockstep_delay_line.sv
verilog/acc_core.sv
verilog/lockstep_compare.sv
verilog/acc_lockstep.sv
sim/tb_acc_lockstep.sv

//--- verilog/acc_core.sv
`timescale 1ns/1ps
`default_nettype none

module acc_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_cmd_t cmd_i,
  output core_rsp_t rsp_o,
  output logic      alert_minor_o
);

  core_rsp_t         rsp_d;
  core_rsp_t         rsp_q;
  logic [DATA_W-1:0] acc_nxt;
  logic              op_legal;

  //////////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////////

  // The accumulator lives in the result field of the response register
  always_comb begin
    op_legal = 1'b1;
    acc_nxt  = rsp_q.result;
    case (cmd_i.op)
      OP_LOAD: acc_nxt = cmd_i.operand;
      OP_ADD:  acc_nxt = rsp_q.result + cmd_i.operand;
      OP_SUB:  acc_nxt = rsp_q.result - cmd_i.operand;
      OP_XOR:  acc_nxt = rsp_q.result ^ cmd_i.operand;
      OP_AND:  acc_nxt = rsp_q.result & cmd_i.operand;
      default: op_legal = 1'b0;
    endcase
  end

  always_comb begin
    rsp_d.rsp_valid = cmd_i.cmd_valid;
    rsp_d.illegal   = cmd_i.cmd_valid & ~op_legal;
    // Idle cycles and illegal opcodes keep the old value
    rsp_d.result    = (cmd_i.cmd_valid && op_legal) ? acc_nxt : rsp_q.result;
  end

  //////////////////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

  // Minor alert pulses together with the illegal flag
  assign alert_minor_o = rsp_q.illegal;

  // Every command gets exactly one response, one cycle later
  a_rsp_follows_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> (rsp_o.rsp_valid == $past(cmd_i.cmd_valid)))
    else $error("rsp_valid does not follow cmd_valid");

endmodule

`default_nettype wire

//--- verilog/acc_lockstep.sv
`timescale 1ns/1ps
`default_nettype none

module acc_lockstep import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Main core command and its registered response
  input  core_cmd_t cmd_i,
  input  core_rsp_t main_rsp_i,

  output logic      alert_major_o,
  output logic      alert_minor_o
);

  logic      shadow_rst_n;
  logic      cmp_en;
  core_cmd_t shadow_cmd;
  core_rsp_t shadow_rsp;
  core_rsp_t main_rsp_dly;
  logic      shadow_alert_minor;

  //////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////////////////////////////

  lockstep_rst_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////////////////////
  // Shadow core and its input delay
  //////////////////////////////////////////////////////////////////////////

  lockstep_delay_line #(
    .DEPTH  (LOCKSTEP_OFFSET),
    .data_t (core_cmd_t)
  ) cmd_dly_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (cmd_i),
    .data_o (shadow_cmd)
  );

  acc_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (shadow_rst_n),
    .cmd_i         (shadow_cmd),
    .rsp_o         (shadow_rsp),
    .alert_minor_o (shadow_alert_minor)
  );

  //////////////////////////////////////////////////////////////////////////
  // Output alignment and comparison
  //////////////////////////////////////////////////////////////////////////

  // Extra stage matches the shadow output register in the comparator
  lockstep_delay_line #(
    .DEPTH  (OUTPUTS_OFFSET),
    .data_t (core_rsp_t)
  ) rsp_dly_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_rsp_i),
    .data_o (main_rsp_dly)
  );

  lockstep_compare u_compare (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmp_en_i             (cmp_en),
    .shadow_rsp_i         (shadow_rsp),
    .main_rsp_i           (main_rsp_dly),
    .shadow_alert_minor_i (shadow_alert_minor),
    .alert_major_o        (alert_major_o),
    .alert_minor_o        (alert_minor_o)
  );

endmodule

`default_nettype wire

//--- verilog/lockstep_compare.sv
`timescale 1ns/1ps
`default_nettype none

module lockstep_compare import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmp_en_i,
  input  core_rsp_t shadow_rsp_i,
  input  core_rsp_t main_rsp_i,
  input  logic      shadow_alert_minor_i,
  output logic      alert_major_o,
  output logic      alert_minor_o
);

  core_rsp_t shadow_rsp_q;
  logic      rsp_mismatch;

  //////////////////////////////////////////////////////////////////////////
  // Shadow output register
  //////////////////////////////////////////////////////////////////////////

  // Cuts the path from the shadow core to the alert logic
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_rsp_q <= '0;
    end else begin
      shadow_rsp_q <= shadow_rsp_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Comparison and alerts
  //////////////////////////////////////////////////////////////////////////

  // Main response arrives already delayed by OUTPUTS_OFFSET
  assign rsp_mismatch = (shadow_rsp_q != main_rsp_i);

  assign alert_major_o = cmp_en_i & rsp_mismatch;
  assign alert_minor_o = cmp_en_i & shadow_alert_minor_i;

  // Start-up garbage from the pipelines must never leak out as an alert
  a_no_alert_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cmp_en_i |-> !(alert_major_o || alert_minor_o))
    else $error("alert raised while compare is disabled");

endmodule

`default_nettype wire

//--- verilog/lockstep_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module lockstep_delay_line #(
  parameter int unsigned DEPTH  = 1,
  parameter type         data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  data_t data_i,
  output data_t data_o
);

  // Stage 0 takes the newest item and the last stage feeds the output
  data_t stage_q [DEPTH];

  if (DEPTH == 0) begin : g_depth_check
    $error("lockstep_delay_line needs DEPTH of at least one");
  end

  //////////////////////////////////////////////////////////////////////////
  // Shift register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        stage_q[i] <= data_t'('0);
      end
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/lockstep_pkg.sv
`default_nettype none

package lockstep_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Lockstep timing
  //////////////////////////////////////////////////////////////////////////

  // Cycles the shadow core trails the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;

  // Main core outputs wait one more cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;

  // Shadow reset release counter is at least one bit wide
  localparam int unsigned RST_CNT_W = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  //////////////////////////////////////////////////////////////////////////
  // Accumulator core interface
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;

  // Codes 5 to 7 are illegal
  typedef enum logic [2:0] {
    OP_LOAD = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_XOR  = 3'd3,
    OP_AND  = 3'd4
  } acc_op_e;

  // Core inputs, 36 bits
  typedef struct packed {
    logic              cmd_valid;
    acc_op_e           op;
    logic [DATA_W-1:0] operand;
  } core_cmd_t;

  // Core outputs, 34 bits
  typedef struct packed {
    logic              rsp_valid;
    // Previous command was valid with an illegal opcode
    logic              illegal;
    logic [DATA_W-1:0] result;
  } core_rsp_t;

endpackage

`default_nettype wire

//--- verilog/lockstep_rst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lockstep_rst_ctrl import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  logic [RST_CNT_W-1:0] cnt_d;
  logic [RST_CNT_W-1:0] cnt_q;
  logic                 cnt_done;
  logic                 shadow_set_q;
  logic                 cmp_en_q;

  //////////////////////////////////////////////////////////////////////////
  // Release sequence
  //////////////////////////////////////////////////////////////////////////

  // Saturate once the input delay line holds real commands
  assign cnt_done = (cnt_q == RST_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d    = cnt_done ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      shadow_set_q <= 1'b0;
      cmp_en_q     <= 1'b0;
    end else begin
      cnt_q        <= cnt_d;
      // Synchronous release of the shadow reset
      shadow_set_q <= cnt_done;
      // Compare one cycle after the shadow core leaves reset
      cmp_en_q     <= shadow_set_q;
    end
  end

  assign shadow_rst_no = shadow_set_q;
  assign cmp_en_o      = cmp_en_q;

  // Comparison only starts once the shadow core has run for a full cycle
  a_cmp_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o |-> shadow_rst_no && $past(shadow_rst_no))
    else $error("compare enabled while shadow core still in reset");

endmodule

`default_nettype wire
